/* Bender.yml */
package:
  name: mem_server

sources:
  - include_dirs:
      - hw
    files:
      - hw/mem_pkg.sv
      - hw/mem_intf.sv
      - hw/delay_stream.sv
      - hw/mem_array.sv
      - hw/mem_server.sv
      - hw/mem_server_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/mem_server_tb.sv

/* compile.f */
+incdir+hw
hw/mem_pkg.sv
hw/mem_intf.sv
hw/delay_stream.sv
hw/mem_array.sv
hw/mem_server.sv
hw/mem_server_top.sv
verification/mem_server_tb.sv

/* hw/delay_stream.sv */
// Paced message queue
// Circular FIFO whose head is released only after waiting p_delay cycles

`timescale 1ns/1ns
`include "mem_macros.svh"

module delay_stream #(
  parameter int p_delay = 1
) (
  input  logic                clk,
  input  logic                rst,
  mem_intf.receiver           in,
  mem_intf.sender             out,
  output mem_pkg::mem_slots_t free_slots
);

  localparam int depth = `MEM_QUEUE_DEPTH;
  localparam int ptr_w = $clog2(depth);
  localparam int age_w = (p_delay > 0) ? $clog2(p_delay + 1) : 1;

  typedef logic [ptr_w-1:0] ptr_t;
  typedef logic [age_w-1:0] age_t;

  localparam age_t                age_max = age_t'(p_delay);
  localparam mem_pkg::mem_slots_t full_c  = mem_pkg::mem_slots_t'(depth);

  // Entry payload
  mem_pkg::mem_op_e     op_q     [depth];
  mem_pkg::mem_addr_t   addr_q   [depth];
  mem_pkg::mem_len_t    len_q    [depth];
  mem_pkg::mem_data_t   data_q   [depth];
  mem_pkg::mem_opaque_t opaque_q [depth];

  // Per-entry wait counter, saturates at p_delay
  age_t age_q [depth];

  ptr_t                wr_ptr;
  ptr_t                rd_ptr;
  mem_pkg::mem_slots_t count;

  logic push;
  logic pop;

  // --------------------
  // Handshakes
  // --------------------

  assign push = in.val && in.rdy;
  assign pop  = out.val && out.rdy;

  // Back-pressure only when every slot is taken
  assign in.rdy     = (count != full_c);
  assign free_slots = full_c - count;

  // Head shown once it has aged enough
  assign out.val    = (count != '0) && (age_q[rd_ptr] == age_max);
  assign out.op     = op_q[rd_ptr];
  assign out.addr   = addr_q[rd_ptr];
  assign out.len    = len_q[rd_ptr];
  assign out.data   = data_q[rd_ptr];
  assign out.opaque = opaque_q[rd_ptr];

  // --------------------
  // Pointers and count
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Net occupancy change
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Payload capture
  always_ff @(posedge clk) begin
    if (push) begin
      op_q[wr_ptr]     <= in.op;
      addr_q[wr_ptr]   <= in.addr;
      len_q[wr_ptr]    <= in.len;
      data_q[wr_ptr]   <= in.data;
      opaque_q[wr_ptr] <= in.opaque;
    end
  end

  // Fresh entry restarts its counter, others count up to the limit
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < depth; i++) begin
        age_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < depth; i++) begin
        if (push && (ptr_t'(i) == wr_ptr)) begin
          age_q[i] <= '0;
        end else if (age_q[i] != age_max) begin
          age_q[i] <= age_q[i] + 1'b1;
        end
      end
    end
  end

  // --------------------
  // Checks
  // --------------------

  // A sender held off by a full queue keeps its message
  a_in_hold: assert property (@(posedge clk) disable iff (rst)
    (in.val && !in.rdy) |=> (in.val && $stable(in.op) && $stable(in.addr)
      && $stable(in.len) && $stable(in.data) && $stable(in.opaque)));

  // Stalled head must not change under the consumer
  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    (out.val && !out.rdy) |=> (out.val && $stable(out.op) && $stable(out.addr)
      && $stable(out.len) && $stable(out.data) && $stable(out.opaque)));

endmodule

/* hw/mem_array.sv */
// Word storage for the memory server
// Byte-enabled writes by length, per-word written flags, registered read

`timescale 1ns/1ns
`include "mem_macros.svh"

module mem_array (
  input  logic                clk,
  input  logic                rst,
  input  logic                wr_en,
  input  mem_pkg::mem_index_t wr_index,
  input  mem_pkg::mem_len_t   wr_len,
  input  mem_pkg::mem_data_t  wr_data,
  input  logic                rd_en,
  input  mem_pkg::mem_index_t rd_index,
  output mem_pkg::mem_data_t  rd_data
);

  localparam int bytes = `MEM_DATA_W / 8;

  mem_pkg::mem_data_t words [`MEM_WORDS];

  // One bit per word, set by the first write
  logic [`MEM_WORDS-1:0] written;

  logic [bytes-1:0] byte_en;
  int               byte_cnt;

  // --------------------
  // Byte enables
  // --------------------

  // Zero length means the full word, otherwise the low bytes
  always_comb begin
    byte_cnt = (wr_len == '0) ? bytes : int'(wr_len);
    for (int b = 0; b < bytes; b++) begin
      byte_en[b] = (b < byte_cnt);
    end
  end

  // Storage update
  // Bytes left out of a first write read back as zero
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < bytes; b++) begin
        if (byte_en[b]) begin
          words[wr_index][8*b +: 8] <= wr_data[8*b +: 8];
        end else if (!written[wr_index]) begin
          words[wr_index][8*b +: 8] <= 8'h00;
        end
      end
    end
  end

  // Written flags, cleared by reset
  always_ff @(posedge clk) begin
    if (rst) begin
      written <= '0;
    end else if (wr_en) begin
      written[wr_index] <= 1'b1;
    end
  end

  // Registered read, zero for untouched words
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= written[rd_index] ? words[rd_index] : '0;
    end
  end

  // The engine issues one access per cycle
  a_no_rw_clash: assert property (@(posedge clk) disable iff (rst)
    !(rd_en && wr_en && (rd_index == wr_index)));

endmodule

/* hw/mem_intf.sv */
// Memory message channel
// One valid/ready link carrying a request or a response

`timescale 1ns/1ns

interface mem_intf;

  // --------------------
  // Handshake
  // --------------------

  logic val;
  logic rdy;

  // --------------------
  // Message fields
  // --------------------

  mem_pkg::mem_op_e     op;
  mem_pkg::mem_addr_t   addr;
  mem_pkg::mem_len_t    len;
  mem_pkg::mem_data_t   data;
  mem_pkg::mem_opaque_t opaque;

  // Producer side, holds fields steady while val waits on rdy
  modport sender (
    output val,
    input  rdy,
    output op,
    output addr,
    output len,
    output data,
    output opaque
  );

  // Consumer side
  modport receiver (
    input  val,
    output rdy,
    input  op,
    input  addr,
    input  len,
    input  data,
    input  opaque
  );

endinterface

/* hw/mem_macros.svh */
// Memory server build constants
// Word and address widths, storage depth, queue depth and pacing delays

`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// --------------------
// Data path widths
// --------------------

// Bits per data word
`define MEM_DATA_W 32
// Bits per byte address
`define MEM_ADDR_W 16

// --------------------
// Storage and queues
// --------------------

// Words in the on-chip array
`define MEM_WORDS 256
// Entries per paced stream
`define MEM_QUEUE_DEPTH 4

// Cycles a request waits before the engine may see it
`define MEM_REQ_DELAY 2
// Cycles a response waits before leaving the server
`define MEM_RESP_DELAY 1

`endif

/* hw/mem_pkg.sv */
// Memory server shared types
// Message field types and the operation encoding

`include "mem_macros.svh"

package mem_pkg;

  // --------------------
  // Operation
  // --------------------

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // --------------------
  // Message fields
  // --------------------

  // Byte address as seen by the client
  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
  // One storage word
  typedef logic [`MEM_DATA_W-1:0] mem_data_t;
  // Byte count, 0 selects the whole word
  typedef logic [1:0] mem_len_t;
  // Client tag, returned untouched
  typedef logic [7:0] mem_opaque_t;

  // Word slot in the array
  typedef logic [$clog2(`MEM_WORDS)-1:0] mem_index_t;

  // Free entry count of a stream, 0 up to full depth
  typedef logic [$clog2(`MEM_QUEUE_DEPTH+1)-1:0] mem_slots_t;

endpackage

/* hw/mem_server.sv */
// Memory request engine
// Two-stage pipeline from paced requests to array access to responses
// Credits keep the response stream from overflowing

`timescale 1ns/1ns
`include "mem_macros.svh"

module mem_server (
  input  logic                clk,
  input  logic                rst,
  mem_intf.receiver           req,
  mem_intf.sender             resp,
  input  mem_pkg::mem_slots_t resp_free,
  output logic                wr_en,
  output mem_pkg::mem_index_t wr_index,
  output mem_pkg::mem_len_t   wr_len,
  output mem_pkg::mem_data_t  wr_data,
  output logic                rd_en,
  output mem_pkg::mem_index_t rd_index,
  input  mem_pkg::mem_data_t  rd_data
);

  localparam int idx_lsb = $clog2(`MEM_DATA_W / 8);
  localparam int slots_w = $bits(mem_pkg::mem_slots_t);

  logic                accept;
  logic                push;
  logic                loaded;
  mem_pkg::mem_slots_t credits;
  mem_pkg::mem_slots_t prev_free;
  logic                prev_push;
  logic [slots_w:0]    free_sum;
  logic                returned;

  // Stage 1 holds the request while the array answers
  logic                 s1_val;
  mem_pkg::mem_op_e     s1_op;
  mem_pkg::mem_addr_t   s1_addr;
  mem_pkg::mem_len_t    s1_len;
  mem_pkg::mem_opaque_t s1_opaque;

  // Stage 2 is the response register
  logic s2_val;

  // --------------------
  // Credits
  // --------------------

  assign accept  = req.val && req.rdy;
  assign push    = resp.val && resp.rdy;
  assign req.rdy = loaded && (credits != '0);

  // A slot came back if free rose by more than our own push removed
  assign free_sum = {1'b0, resp_free} + (slots_w + 1)'(prev_push);
  assign returned = (free_sum != {1'b0, prev_free});

  always_ff @(posedge clk) begin
    if (rst) begin
      loaded    <= 1'b0;
      credits   <= '0;
      prev_free <= '0;
      prev_push <= 1'b0;
    end else begin
      loaded    <= 1'b1;
      prev_free <= resp_free;
      prev_push <= push;
      if (!loaded) begin
        credits <= resp_free;
      end else begin
        credits <= credits - slots_w'(accept) + slots_w'(returned);
      end
    end
  end

  // --------------------
  // Stage 1, array access
  // --------------------

  assign wr_en    = accept && (req.op == mem_pkg::MEM_WRITE);
  assign rd_en    = accept && (req.op == mem_pkg::MEM_READ);
  assign wr_index = req.addr[idx_lsb +: $bits(mem_pkg::mem_index_t)];
  assign rd_index = req.addr[idx_lsb +: $bits(mem_pkg::mem_index_t)];
  assign wr_len   = req.len;
  assign wr_data  = req.data;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_val <= 1'b0;
    end else begin
      s1_val <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_op     <= req.op;
      s1_addr   <= req.addr;
      s1_len    <= req.len;
      s1_opaque <= req.opaque;
    end
  end

  // --------------------
  // Stage 2, response
  // --------------------

  // Credits guarantee the stream takes s2 before s1 refills it
  always_ff @(posedge clk) begin
    if (rst) begin
      s2_val <= 1'b0;
    end else if (s1_val) begin
      s2_val <= 1'b1;
    end else if (push) begin
      s2_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_val) begin
      resp.op     <= s1_op;
      resp.addr   <= s1_addr;
      resp.len    <= s1_len;
      resp.opaque <= s1_opaque;
      // Writes answer with zero data
      resp.data   <= (s1_op == mem_pkg::MEM_READ) ? rd_data : '0;
    end
  end

  assign resp.val = s2_val;

  // Counter never promises more slots than the stream still has
  a_credit_floor: assert property (@(posedge clk) disable iff (rst)
    loaded |-> (int'(credits) + int'(s1_val) + int'(s2_val) <= int'(resp_free)));

endmodule

/* hw/mem_server_top.sv */
// Memory server top level
// Request stream, engine, word array and response stream behind plain ports

`timescale 1ns/1ns
`include "mem_macros.svh"

module mem_server_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_val,
  output logic                 req_rdy,
  input  mem_pkg::mem_op_e     req_op,
  input  mem_pkg::mem_addr_t   req_addr,
  input  mem_pkg::mem_len_t    req_len,
  input  mem_pkg::mem_data_t   req_data,
  input  mem_pkg::mem_opaque_t req_opaque,
  output logic                 resp_val,
  input  logic                 resp_rdy,
  output mem_pkg::mem_op_e     resp_op,
  output mem_pkg::mem_addr_t   resp_addr,
  output mem_pkg::mem_len_t    resp_len,
  output mem_pkg::mem_data_t   resp_data,
  output mem_pkg::mem_opaque_t resp_opaque
);

  mem_intf ext_req ();
  mem_intf req_ch ();
  mem_intf resp_ch ();
  mem_intf ext_resp ();

  mem_pkg::mem_slots_t resp_free;

  logic                wr_en;
  mem_pkg::mem_index_t wr_index;
  mem_pkg::mem_len_t   wr_len;
  mem_pkg::mem_data_t  wr_data;
  logic                rd_en;
  mem_pkg::mem_index_t rd_index;
  mem_pkg::mem_data_t  rd_data;

  // --------------------
  // Client side ports
  // --------------------

  assign ext_req.val    = req_val;
  assign ext_req.op     = req_op;
  assign ext_req.addr   = req_addr;
  assign ext_req.len    = req_len;
  assign ext_req.data   = req_data;
  assign ext_req.opaque = req_opaque;
  assign req_rdy        = ext_req.rdy;

  assign ext_resp.rdy = resp_rdy;
  assign resp_val     = ext_resp.val;
  assign resp_op      = ext_resp.op;
  assign resp_addr    = ext_resp.addr;
  assign resp_len     = ext_resp.len;
  assign resp_data    = ext_resp.data;
  assign resp_opaque  = ext_resp.opaque;

  // --------------------
  // Datapath
  // --------------------

  // Request side free count is not needed by anyone
  delay_stream #(.p_delay(`MEM_REQ_DELAY)) req_stream (
    .clk        (clk),
    .rst        (rst),
    .in         (ext_req.receiver),
    .out        (req_ch.sender),
    .free_slots ()
  );

  mem_server engine (
    .clk       (clk),
    .rst       (rst),
    .req       (req_ch.receiver),
    .resp      (resp_ch.sender),
    .resp_free (resp_free),
    .wr_en     (wr_en),
    .wr_index  (wr_index),
    .wr_len    (wr_len),
    .wr_data   (wr_data),
    .rd_en     (rd_en),
    .rd_index  (rd_index),
    .rd_data   (rd_data)
  );

  mem_array storage (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_len   (wr_len),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_index (rd_index),
    .rd_data  (rd_data)
  );

  delay_stream #(.p_delay(`MEM_RESP_DELAY)) resp_stream (
    .clk        (clk),
    .rst        (rst),
    .in         (resp_ch.receiver),
    .out        (ext_resp.sender),
    .free_slots (resp_free)
  );

endmodule

/* verification/mem_server_tb.sv */
// Memory server testbench
// Directed tests against a word model with written flags
// A background consumer checks every response in request order

`timescale 1ns/1ns
`include "mem_macros.svh"

module mem_server_tb;

  // --------------------
  // Run limits
  // --------------------

  localparam int total_reqs  = 50;
  localparam int cycle_limit =
    total_reqs * (`MEM_REQ_DELAY + `MEM_RESP_DELAY + 2 + 8) + 300;
  localparam int drain_limit = 200;

  logic                 clk;
  logic                 rst;
  logic                 req_val;
  logic                 req_rdy;
  mem_pkg::mem_op_e     req_op;
  mem_pkg::mem_addr_t   req_addr;
  mem_pkg::mem_len_t    req_len;
  mem_pkg::mem_data_t   req_data;
  mem_pkg::mem_opaque_t req_opaque;
  logic                 resp_val;
  logic                 resp_rdy;
  mem_pkg::mem_op_e     resp_op;
  mem_pkg::mem_addr_t   resp_addr;
  mem_pkg::mem_len_t    resp_len;
  mem_pkg::mem_data_t   resp_data;
  mem_pkg::mem_opaque_t resp_opaque;

  // Reference word store
  mem_pkg::mem_data_t model_words [`MEM_WORDS];
  bit                 model_written [`MEM_WORDS];

  // Expected responses, oldest first
  mem_pkg::mem_op_e     exp_op[$];
  mem_pkg::mem_addr_t   exp_addr[$];
  mem_pkg::mem_len_t    exp_len[$];
  mem_pkg::mem_data_t   exp_data[$];
  mem_pkg::mem_opaque_t exp_opaque[$];

  integer     seed;
  bit         rdy_pattern [256];
  logic [7:0] rdy_ptr;
  bit         toggle_rdy;
  bit         hold_rdy;
  int         mismatches;
  int         other_errors;
  int         sent_count;
  int         resp_count;
  int         cycles;

  mem_server_top mem_server_top_i (
    .clk         (clk),
    .rst         (rst),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_op      (req_op),
    .req_addr    (req_addr),
    .req_len     (req_len),
    .req_data    (req_data),
    .req_opaque  (req_opaque),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_op     (resp_op),
    .resp_addr   (resp_addr),
    .resp_len    (resp_len),
    .resp_data   (resp_data),
    .resp_opaque (resp_opaque)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  // --------------------
  // Compare tasks
  // --------------------

  task automatic check_op(input string name, input mem_pkg::mem_op_e exp,
                          input mem_pkg::mem_op_e act);
    if (act !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t %s expected %s got %s", $time, name, exp.name(), act.name());
    end
  endtask

  task automatic check_addr(input string name, input mem_pkg::mem_addr_t exp,
                            input mem_pkg::mem_addr_t act);
    if (act !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input mem_pkg::mem_data_t exp,
                            input mem_pkg::mem_data_t act);
    if (act !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_len(input string name, input mem_pkg::mem_len_t exp,
                           input mem_pkg::mem_len_t act);
    if (act !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_opaque(input string name, input mem_pkg::mem_opaque_t exp,
                              input mem_pkg::mem_opaque_t act);
    if (act !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // --------------------
  // Model and driver
  // --------------------

  // Unwritten words hold zero, so a first partial write leaves zero upper bytes
  task automatic model_request(input mem_pkg::mem_op_e op, input mem_pkg::mem_addr_t addr,
                               input mem_pkg::mem_len_t len, input mem_pkg::mem_data_t data,
                               input mem_pkg::mem_opaque_t tag);
    mem_pkg::mem_index_t idx;
    int                  nbytes;
    // Word index sits in address bits 9 to 2
    idx = addr[9:2];
    exp_op.push_back(op);
    exp_addr.push_back(addr);
    exp_len.push_back(len);
    exp_opaque.push_back(tag);
    if (op == mem_pkg::MEM_WRITE) begin
      // Length 0 is a full word
      nbytes = (len == 2'd0) ? (`MEM_DATA_W / 8) : int'(len);
      for (int b = 0; b < nbytes; b++) begin
        model_words[idx][8*b +: 8] = data[8*b +: 8];
      end
      model_written[idx] = 1'b1;
      exp_data.push_back('0);
    end else begin
      exp_data.push_back(model_written[idx] ? model_words[idx] : '0);
    end
    sent_count++;
  endtask

  // Transfer happens at the posedge after req_rdy is seen high
  task automatic send_req(input mem_pkg::mem_op_e op, input mem_pkg::mem_addr_t addr,
                          input mem_pkg::mem_len_t len, input mem_pkg::mem_data_t data,
                          input mem_pkg::mem_opaque_t tag);
    @(negedge clk);
    req_val    = 1'b1;
    req_op     = op;
    req_addr   = addr;
    req_len    = len;
    req_data   = data;
    req_opaque = tag;
    while (req_rdy !== 1'b1) begin
      @(negedge clk);
    end
    model_request(op, addr, len, data, tag);
  endtask

  task automatic idle_req();
    @(negedge clk);
    req_val = 1'b0;
  endtask

  // One response leaving at the coming posedge
  task automatic receive_resp();
    if (exp_op.size() == 0) begin
      other_errors++;
      $display("ERROR t=%0t response arrived with no request outstanding", $time);
    end else begin
      check_op("resp_op", exp_op.pop_front(), resp_op);
      check_addr("resp_addr", exp_addr.pop_front(), resp_addr);
      check_len("resp_len", exp_len.pop_front(), resp_len);
      check_data("resp_data", exp_data.pop_front(), resp_data);
      check_opaque("resp_opaque", exp_opaque.pop_front(), resp_opaque);
      resp_count++;
    end
  endtask

  // Outputs are stable from negedge to posedge
  always @(negedge clk) begin
    if (hold_rdy) begin
      resp_rdy = 1'b0;
    end else if (toggle_rdy) begin
      resp_rdy = rdy_pattern[rdy_ptr];
      rdy_ptr  = rdy_ptr + 1'b1;
    end else begin
      resp_rdy = 1'b1;
    end
    if (resp_val === 1'b1 && resp_rdy) begin
      receive_resp();
    end
  end

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_op.size() != 0 && waited < drain_limit) begin
      @(negedge clk);
      waited++;
    end
    if (exp_op.size() != 0) begin
      other_errors++;
      $display("ERROR t=%0t %0d responses never arrived", $time, exp_op.size());
      exp_op.delete();
      exp_addr.delete();
      exp_len.delete();
      exp_data.delete();
      exp_opaque.delete();
    end
  endtask

  // Responses flushed by a reset are no longer owed
  task automatic discard_expected();
    sent_count = sent_count - exp_op.size();
    exp_op.delete();
    exp_addr.delete();
    exp_len.delete();
    exp_data.delete();
    exp_opaque.delete();
  endtask

  // Reset also wipes the model
  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      model_words[i]   = '0;
      model_written[i] = 1'b0;
    end
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic write_then_read();
    send_req(mem_pkg::MEM_WRITE, 16'h0040, 2'd0, 32'hdeadbeef, 8'h11);
    send_req(mem_pkg::MEM_READ, 16'h0040, 2'd0, 32'h0, 8'h12);
    idle_req();
    wait_drain();
  endtask

  // Upper data bytes set to show they are masked
  task automatic partial_writes();
    send_req(mem_pkg::MEM_WRITE, 16'h0100, 2'd0, 32'h11223344, 8'h21);
    send_req(mem_pkg::MEM_WRITE, 16'h0100, 2'd1, 32'hffffffa1, 8'h22);
    send_req(mem_pkg::MEM_WRITE, 16'h0100, 2'd2, 32'heeeeb2b2, 8'h23);
    send_req(mem_pkg::MEM_WRITE, 16'h0100, 2'd3, 32'hddc3c3c3, 8'h24);
    send_req(mem_pkg::MEM_READ, 16'h0100, 2'd0, 32'h0, 8'h25);
    idle_req();
    wait_drain();
  endtask

  task automatic unwritten_read();
    send_req(mem_pkg::MEM_READ, 16'h03fc, 2'd0, 32'h0, 8'h31);
    idle_req();
    wait_drain();
  endtask

  task automatic random_backpressure();
    mem_pkg::mem_op_e     op;
    mem_pkg::mem_addr_t   addr;
    mem_pkg::mem_len_t    len;
    mem_pkg::mem_data_t   data;
    mem_pkg::mem_opaque_t tag;
    for (int i = 0; i < 256; i++) begin
      rdy_pattern[i] = $random(seed) & 1;
    end
    rdy_ptr = '0;
    // Switch on between edges
    @(posedge clk);
    toggle_rdy = 1'b1;
    for (int i = 0; i < 40; i++) begin
      op   = mem_pkg::mem_op_e'($random(seed) & 1);
      addr = mem_pkg::mem_addr_t'($random(seed));
      len  = mem_pkg::mem_len_t'($random(seed));
      data = mem_pkg::mem_data_t'($random(seed));
      tag  = mem_pkg::mem_opaque_t'($random(seed));
      send_req(op, addr, len, data, tag);
    end
    idle_req();
    wait_drain();
    @(posedge clk);
    toggle_rdy = 1'b0;
  endtask

  // Write response is parked at the output when reset hits
  task automatic reset_clears_flags();
    int waited;
    waited   = 0;
    hold_rdy = 1'b1;
    send_req(mem_pkg::MEM_WRITE, 16'h0080, 2'd0, 32'hcafef00d, 8'h51);
    idle_req();
    while (resp_val !== 1'b1 && waited < drain_limit) begin
      @(negedge clk);
      waited++;
    end
    if (resp_val !== 1'b1) begin
      other_errors++;
      $display("ERROR t=%0t write response never reached the output", $time);
    end
    apply_reset();
    discard_expected();
    hold_rdy = 1'b0;
    if (resp_val !== 1'b0) begin
      other_errors++;
      $display("ERROR t=%0t resp_val not low right after reset", $time);
    end
    send_req(mem_pkg::MEM_READ, 16'h0080, 2'd0, 32'h0, 8'h52);
    idle_req();
    wait_drain();
  endtask

  // --------------------
  // Watchdog
  // --------------------

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("ERROR timeout, run did not complete within %0d cycles", cycle_limit);
      $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors + 1);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    seed         = 32'h112c;
    clk          = 1'b0;
    rst          = 1'b1;
    req_val      = 1'b0;
    req_op       = mem_pkg::MEM_READ;
    req_addr     = '0;
    req_len      = '0;
    req_data     = '0;
    req_opaque   = '0;
    resp_rdy     = 1'b1;
    toggle_rdy   = 1'b0;
    hold_rdy     = 1'b0;
    rdy_ptr      = '0;
    mismatches   = 0;
    other_errors = 0;
    sent_count   = 0;
    resp_count   = 0;
    cycles       = 0;

    apply_reset();
    write_then_read();
    partial_writes();
    unwritten_read();
    random_backpressure();
    reset_clears_flags();

    if (resp_count != sent_count) begin
      other_errors++;
      $display("ERROR %0d requests sent but %0d responses checked", sent_count, resp_count);
    end

    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
